/* logic/rv_core_pkg.sv */
package rv_core_pkg;

    // datapath widths
    localparam int xlen = 64;                          // data and address width
    localparam int ilen = 32;                          // instruction word width

    // program counter constants
    localparam logic [xlen-1:0] reset_pc = 64'h0000_0000_0000_1000; // same value as ram base
    localparam logic [xlen-1:0] isr_base = 64'h0;      // single fixed interrupt entry
    localparam logic [xlen-1:0] pc_step  = 64'd4;      // bytes per instruction

    // instruction encodings
    localparam logic [6:0]      op_lui       = 7'b0110111;
    localparam logic [ilen-1:0] enc_mret     = 32'h0000_0000;  // all zeros word
    localparam logic [ilen-1:0] enc_load_key = 32'hffff_ffff;  // key register into x5
    localparam logic [ilen-1:0] enc_store_x5 = 32'hffff_ff7f;  // rd field 30, x5 to uart
    localparam logic [ilen-1:0] enc_nop      = 32'h0000_0001;  // matches no decode, ir reset value

    // load target and store source
    localparam logic [4:0] data_reg = 5'd5;

    // external interrupt request code on irq_vector
    localparam logic [3:0] ext_irq_code = 4'd1;

    // mstatus bit positions
    localparam int mstatus_mie  = 3;
    localparam int mstatus_mpie = 7;

    // hart to trap register strobes
    // enter and leave are one cycle wide, epc only matters with enter
    typedef struct packed {
        logic            enter;   // trap entry
        logic            leave;   // mret retired
        logic [xlen-1:0] epc;     // pc to save on entry
    } trap_ctl_t;

endpackage

/* logic/soc_map_pkg.sv */
package soc_map_pkg;

    // device address map
    // ram holds the program, the testbench serves it from pc
    localparam logic [rv_core_pkg::xlen-1:0] ram_base  = 64'h0000_0000_0000_1000;
    localparam logic [rv_core_pkg::xlen-1:0] key_base  = 64'h0000_0000_1000_0000; // key input
    localparam logic [rv_core_pkg::xlen-1:0] uart_base = 64'h0000_0000_1000_0008; // uart tx

    // hart to peripheral request
    // registered in the hart, strobes are single cycle pulses
    typedef struct packed {
        logic [rv_core_pkg::xlen-1:0] address;
        logic [rv_core_pkg::xlen-1:0] write_data;
        logic                         write_enable;  // store strobe
        logic                         read_enable;   // load strobe
    } bus_req_t;

    // true for the two decoded device addresses
    function automatic logic is_mapped(input logic [rv_core_pkg::xlen-1:0] addr);
        logic hit;
        hit = (addr == key_base) || (addr == uart_base);
        return hit;
    endfunction

endpackage

/* logic/trap_csr.sv */
`timescale 1ns/1ps

module trap_csr (
    input  logic                           clk,
    input  logic                           reset,
    input  rv_core_pkg::trap_ctl_t         trap_ctl,    // strobes from hart
    output logic                           irq_enable,  // mstatus.MIE level
    output logic [rv_core_pkg::xlen-1:0]   mepc
);

    // only MIE and MPIE are implemented, remaining bits read zero
    logic [rv_core_pkg::xlen-1:0] mstatus;
    logic [rv_core_pkg::xlen-1:0] mepc_q;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mstatus                           <= '0;
            mstatus[rv_core_pkg::mstatus_mie]  <= 1'b1;  // interrupts on out of reset
            mstatus[rv_core_pkg::mstatus_mpie] <= 1'b1;
            mepc_q                            <= '0;
        end else if (trap_ctl.enter) begin
            // stack MIE into MPIE, then mask
            mstatus[rv_core_pkg::mstatus_mpie] <= mstatus[rv_core_pkg::mstatus_mie];
            mstatus[rv_core_pkg::mstatus_mie]  <= 1'b0;
            mepc_q                            <= trap_ctl.epc;  // return point
        end else if (trap_ctl.leave) begin
            // mret pops the enable back
            mstatus[rv_core_pkg::mstatus_mie]  <= mstatus[rv_core_pkg::mstatus_mpie];
            mstatus[rv_core_pkg::mstatus_mpie] <= 1'b1;
        end
    end

    // read side is combinational, hart sees new MIE the cycle after the strobe
    assign irq_enable = mstatus[rv_core_pkg::mstatus_mie];
    assign mepc       = mepc_q;

    // hart never retires mret in the same cycle it takes an interrupt
    a_enter_leave_excl : assert property (
        @(posedge clk) disable iff (!reset)
        !(trap_ctl.enter && trap_ctl.leave)
    );

endmodule

/* logic/hart_core.sv */
`timescale 1ns/1ps

module hart_core (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [rv_core_pkg::ilen-1:0]   instruction,  // fetched word at pc
    input  logic [3:0]                     irq_vector,
    input  logic                           irq_enable,   // MIE from trap_csr
    input  logic [rv_core_pkg::xlen-1:0]   mepc,
    input  logic [rv_core_pkg::xlen-1:0]   read_data,    // from io_port
    output logic [rv_core_pkg::xlen-1:0]   pc,
    output logic                           irq_ack,
    output logic                           heartbeat,
    output rv_core_pkg::trap_ctl_t         trap_ctl,
    output soc_map_pkg::bus_req_t          bus_req
);

    logic [rv_core_pkg::ilen-1:0] ir;          // fetch register
    logic [rv_core_pkg::xlen-1:0] regs [32];   // general registers, x0 never written
    logic                         bubble;      // flush next execute slot
    logic                         load_step;   // second half of the key load

    // decode
    logic [4:0]                   rd;
    logic [rv_core_pkg::xlen-1:0] imm_u;
    logic                         is_lui;
    logic                         is_mret;
    logic                         is_load;
    logic                         is_store;

    // slot arbitration
    logic take_irq;   // interrupt entry wins over everything
    logic exec_slot;  // ir really executes this cycle

    // register file write port
    logic                         rf_we;
    logic [4:0]                   rf_waddr;
    logic [rv_core_pkg::xlen-1:0] rf_wdata;

    assign rd    = ir[11:7];
    assign imm_u = {{(rv_core_pkg::xlen - rv_core_pkg::ilen){ir[rv_core_pkg::ilen-1]}},
                    ir[rv_core_pkg::ilen-1:12], 12'b0};  // sign extended upper imm

    // exact words first, lui opcode cannot collide with them
    assign is_mret  = (ir == rv_core_pkg::enc_mret);
    assign is_load  = (ir == rv_core_pkg::enc_load_key);
    assign is_store = (ir == rv_core_pkg::enc_store_x5);
    assign is_lui   = (ir[6:0] == rv_core_pkg::op_lui);

    assign take_irq  = (irq_vector == rv_core_pkg::ext_irq_code) && irq_enable;
    assign exec_slot = !take_irq && !bubble;

    // strobes reach trap_csr at the same edge the hart acts on them
    always_comb begin
        trap_ctl.enter = take_irq;
        trap_ctl.leave = exec_slot && is_mret;
        trap_ctl.epc   = pc;  // pc before the jump
    end

    // lui writes rd, second load step writes x5
    always_comb begin
        rf_we    = exec_slot && ((is_lui && rd != 5'd0) || (is_load && load_step));
        rf_waddr = is_load ? rv_core_pkg::data_reg : rd;
        rf_wdata = is_load ? read_data : imm_u;
    end

    always_ff @(posedge clk) begin
        if (rf_we) begin
            regs[rf_waddr] <= rf_wdata;
        end
    end

    // fetch stage, latches whatever the memory shows
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            heartbeat <= 1'b0;
            ir        <= rv_core_pkg::enc_nop;
        end else begin
            heartbeat <= ~heartbeat;
            ir        <= instruction;
        end
    end

    // execute stage
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc        <= rv_core_pkg::reset_pc;
            bubble    <= 1'b0;
            load_step <= 1'b0;
            irq_ack   <= 1'b0;
            bus_req   <= '{address:      soc_map_pkg::ram_base,
                           write_data:   '0,
                           write_enable: 1'b0,
                           read_enable:  1'b0};
        end else begin
            pc                   <= pc + rv_core_pkg::pc_step;  // default, overridden below
            irq_ack              <= 1'b0;
            bus_req.read_enable  <= 1'b0;  // strobes last one cycle
            bus_req.write_enable <= 1'b0;

            if (take_irq) begin
                pc        <= rv_core_pkg::isr_base;
                bubble    <= 1'b1;   // word fetched behind us is stale
                irq_ack   <= 1'b1;
                load_step <= 1'b0;   // interrupted load restarts from mepc
            end else if (bubble) begin
                bubble <= 1'b0;      // drop this slot
            end else if (is_mret) begin
                pc     <= mepc;
                bubble <= 1'b1;
            end else if (is_load) begin
                if (!load_step) begin
                    // issue read, refetch the load so it comes back for step two
                    bus_req.address     <= soc_map_pkg::key_base;
                    bus_req.read_enable <= 1'b1;
                    pc                  <= pc - rv_core_pkg::pc_step;
                    bubble              <= 1'b1;
                    load_step           <= 1'b1;
                end else begin
                    load_step <= 1'b0;  // x5 captured through rf port
                end
            end else if (is_store) begin
                bus_req.address      <= soc_map_pkg::uart_base;
                bus_req.write_data   <= regs[rv_core_pkg::data_reg];
                bus_req.write_enable <= 1'b1;
            end
        end
    end

    a_bus_strobe_excl : assert property (
        @(posedge clk) disable iff (!reset)
        !(bus_req.read_enable && bus_req.write_enable)
    );

    // relies on trap_csr masking MIE right at entry
    a_irq_ack_single : assert property (
        @(posedge clk) disable iff (!reset)
        irq_ack |=> !irq_ack
    );

endmodule

/* logic/io_port.sv */
`timescale 1ns/1ps

module io_port (
    input  logic                           clk,
    input  logic                           reset,
    input  soc_map_pkg::bus_req_t          bus_req,
    input  logic [rv_core_pkg::xlen-1:0]   key,        // raw key pins
    output logic [rv_core_pkg::xlen-1:0]   read_data,  // held until next read
    output logic [rv_core_pkg::xlen-1:0]   tx_data,
    output logic                           tx_valid
);

    logic [rv_core_pkg::xlen-1:0] key_reg;  // sampled every edge
    logic                         hit_key;
    logic                         hit_uart;
    logic                         rd_key;
    logic                         wr_uart;

    // address decode
    assign hit_key  = (bus_req.address == soc_map_pkg::key_base);
    assign hit_uart = (bus_req.address == soc_map_pkg::uart_base);

    // reads only from key, writes only to uart, anything else dropped
    assign rd_key  = bus_req.read_enable && hit_key;
    assign wr_uart = bus_req.write_enable && hit_uart;

    always_ff @(posedge clk) begin
        key_reg <= key;
    end

    // data registers, loaded on strobes only
    always_ff @(posedge clk) begin
        if (rd_key) begin
            read_data <= key_reg;
        end
        if (wr_uart) begin
            tx_data <= bus_req.write_data;  // no back-pressure, overwrite
        end
    end

    // valid follows the write strobe by one edge
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            tx_valid <= 1'b0;
        end else begin
            tx_valid <= wr_uart;
        end
    end

    // hart only ever drives decoded device addresses
    a_strobe_mapped : assert property (
        @(posedge clk) disable iff (!reset)
        (bus_req.read_enable || bus_req.write_enable) |->
            soc_map_pkg::is_mapped(bus_req.address)
    );

endmodule

/* logic/soc_top.sv */
`timescale 1ns/1ps

module soc_top (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [rv_core_pkg::ilen-1:0]   instruction,  // program word at pc
    input  logic [3:0]                     irq_vector,
    input  logic [rv_core_pkg::xlen-1:0]   key,
    output logic [rv_core_pkg::xlen-1:0]   pc,
    output logic                           irq_ack,
    output logic                           heartbeat,
    output logic [rv_core_pkg::xlen-1:0]   tx_data,
    output logic                           tx_valid
);

    rv_core_pkg::trap_ctl_t       trap_ctl;   // hart to trap regs
    soc_map_pkg::bus_req_t        bus_req;    // hart to io
    logic                         irq_enable;
    logic [rv_core_pkg::xlen-1:0] mepc;
    logic [rv_core_pkg::xlen-1:0] read_data;

    hart_core u_hart (
        .clk         (clk),
        .reset       (reset),
        .instruction (instruction),
        .irq_vector  (irq_vector),
        .irq_enable  (irq_enable),
        .mepc        (mepc),
        .read_data   (read_data),
        .pc          (pc),
        .irq_ack     (irq_ack),
        .heartbeat   (heartbeat),
        .trap_ctl    (trap_ctl),
        .bus_req     (bus_req)
    );

    trap_csr u_trap (
        .clk        (clk),
        .reset      (reset),
        .trap_ctl   (trap_ctl),
        .irq_enable (irq_enable),
        .mepc       (mepc)
    );

    io_port u_io (
        .clk       (clk),
        .reset     (reset),
        .bus_req   (bus_req),
        .key       (key),
        .read_data (read_data),
        .tx_data   (tx_data),
        .tx_valid  (tx_valid)
    );

endmodule

/* testbench/soc_tb.sv */
`timescale 1ns/1ps

module soc_tb;

    localparam int image_words = 16;   // words per program region
    localparam int pat_words   = 48;
    localparam int wait_limit  = 200;  // cycles before a wait gives up

    logic                              clk;
    logic                              reset;
    logic [rv_core_pkg::ilen-1:0]      instruction;
    logic [3:0]                        irq_vector;
    logic [rv_core_pkg::xlen-1:0]      key;
    logic [rv_core_pkg::xlen-1:0]      pc;
    logic                              irq_ack;
    logic                              heartbeat;
    logic [rv_core_pkg::xlen-1:0]      tx_data;
    logic                              tx_valid;

    logic [rv_core_pkg::xlen-1:0] pat [pat_words];  // whole patterns image
    logic [rv_core_pkg::xlen-1:0] key_vals [2];
    int                           key_sel;           // key currently on the pins
    int                           n_exp;
    int                           tx_count;
    int                           ack_count;
    logic [rv_core_pkg::xlen-1:0] last_pc;
    logic [rv_core_pkg::xlen-1:0] entry_pc [2];      // pc just before each ack
    logic [rv_core_pkg::xlen-1:0] ack_pc [2];        // pc in the cycle of each ack

    soc_top uut (
        .clk         (clk),
        .reset       (reset),
        .instruction (instruction),
        .irq_vector  (irq_vector),
        .key         (key),
        .pc          (pc),
        .irq_ack     (irq_ack),
        .heartbeat   (heartbeat),
        .tx_data     (tx_data),
        .tx_valid    (tx_valid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // program memory, isr region at word 0, main region at word 16
    function automatic logic [rv_core_pkg::ilen-1:0] fetch_word(input logic [63:0] addr);
        logic [63:0] off;
        off = addr - soc_map_pkg::ram_base;
        if (addr < rv_core_pkg::isr_base + 4 * image_words)
            return pat[addr[5:2]][31:0];
        else if (addr >= soc_map_pkg::ram_base && off < 4 * image_words)
            return pat[image_words + off[5:2]][31:0];
        return rv_core_pkg::enc_nop;  // outside both images
    endfunction

    // lui result as the ISA defines it
    function automatic logic [63:0] upper_imm(input logic [31:0] word);
        return {{32{word[31]}}, word[31:12], 12'h000};
    endfunction

    assign instruction = fetch_word(pc);  // combinational read at pc

    always @(posedge clk) begin
        if (key_sel < 2)
            key <= key_vals[key_sel];
    end

    task automatic report_fail(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s got %h expected %h", name, got, exp);
            report_fail("value check failed");
        end
    endtask

    // transmit stream and ack monitor, sampled mid cycle
    always @(negedge clk) begin
        logic [63:0] exp;
        if (reset && tx_valid) begin
            if (tx_count >= n_exp)
                report_fail("tx_valid pulsed more often than the stream lists");
            exp = pat[40 + tx_count];
            if (exp == '0) begin
                exp     = key_vals[key_sel];  // zero entry stands for the loaded key
                key_sel = key_sel + 1;
            end
            check_value("tx_data", tx_data, exp);
            tx_count = tx_count + 1;
        end
        if (reset && irq_ack) begin
            if (ack_count >= 2)
                report_fail("irq_ack pulsed more than twice");
            entry_pc[ack_count] = last_pc;
            ack_pc[ack_count]   = pc;
            ack_count           = ack_count + 1;
        end
        last_pc = pc;
    end

    // tb counters move at negedge, so poll them at posedge
    task automatic wait_tx(input int target, input string what);
        int n;
        n = 0;
        while (tx_count < target) begin
            @(posedge clk);
            n = n + 1;
            if (n > wait_limit)
                report_fail({"timed out waiting for tx_valid of ", what});
        end
    endtask

    task automatic wait_ack(input int target);
        int n;
        n = 0;
        while (ack_count < target) begin
            @(posedge clk);
            n = n + 1;
            if (n > wait_limit)
                report_fail("timed out waiting for irq_ack");
        end
    endtask

    initial begin
        int n;
        reset      = 1'b0;
        irq_vector = 4'd0;
        key        = '0;
        key_sel    = 0;
        tx_count   = 0;
        ack_count  = 0;
        last_pc    = '0;
        void'($urandom(41));
        $readmemh("testbench/soc_patterns.hex", pat);
        n_exp       = int'(pat[33]);
        key_vals[0] = pat[34];
        key_vals[1] = pat[35];
        if (key_vals[1] == '0)
            key_vals[1] = {$urandom, $urandom};  // zero key marks a random one
        // listed lui results against the instruction words
        check_value("lui main 0", pat[40], upper_imm(pat[16][31:0]));
        check_value("lui main 2", pat[41], upper_imm(pat[18][31:0]));
        check_value("lui isr 0", pat[44], upper_imm(pat[0][31:0]));

        repeat (10) @(posedge clk);
        @(negedge clk);
        check_value("pc", pc, rv_core_pkg::reset_pc);  // still in reset
        check_value("irq_ack", irq_ack, 0);
        check_value("tx_valid", tx_valid, 0);
        check_value("heartbeat", heartbeat, 0);
        @(posedge clk);
        reset <= 1'b1;
        // first toggle comes one edge after release
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            check_value("heartbeat", heartbeat, i[0] ? 1'b1 : 1'b0);
        end

        wait_tx(4, "main program stores");
        n = 9;
        while (n < int'(pat[32])) begin  // hold off until the listed irq cycle
            @(posedge clk);
            n = n + 1;
        end
        irq_vector <= rv_core_pkg::ext_irq_code;
        wait_ack(1);
        check_value("pc at isr entry", ack_pc[0], rv_core_pkg::isr_base);
        wait_tx(5, "first isr store");
        check_value("ack count inside isr", ack_count, 1);
        wait_ack(2);  // request still high, mret opens the door again
        check_value("pc before second entry", entry_pc[1], entry_pc[0]);
        check_value("pc at second entry", ack_pc[1], rv_core_pkg::isr_base);
        @(posedge clk);
        irq_vector <= 4'd0;

        // first pc outside the isr is the mret target
        n = 0;
        @(negedge clk);
        while (pc < soc_map_pkg::ram_base) begin
            @(negedge clk);
            n = n + 1;
            if (n > wait_limit)
                report_fail("pc never returned from the isr");
        end
        check_value("pc after mret", pc, entry_pc[0]);
        wait_tx(6, "second isr store");

        repeat (20) @(posedge clk);  // room for stray pulses
        if (tx_count != n_exp || ack_count != 2) begin
            $display("tx pulses %0d of %0d, acks %0d", tx_count, n_exp, ack_count);
            $display("Errors found");
            $fatal(1);
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

/* testbench/soc_patterns.hex */
// words 00-0f isr image at isr_base, 10-1f main image at ram_base (one word per pc/4)
// 20 irq request cycle, 21 expected count, 22-23 key values (0 random), 28-2d expected tx (0 key)
@00
a5a5a2b7
ffffff7f
00000000
00000001 00000001 00000001 00000001
00000001 00000001 00000001 00000001
00000001 00000001 00000001 00000001
00000001
@10
123452b7
ffffff7f
fedcb2b7
ffffff7f
ffffffff
ffffff7f
00000001 00000001 00000001 00000001
ffffffff
ffffff7f
00000001 00000001 00000001 00000001
@20
0000001e
00000006
0123456789abcdef
0000000000000000
@28
0000000012345000
fffffffffedcb000
0000000000000000
0000000000000000
ffffffffa5a5a000
ffffffffa5a5a000

/* compile.f */
logic/rv_core_pkg.sv
logic/soc_map_pkg.sv
logic/trap_csr.sv
logic/hart_core.sv
logic/io_port.sv
logic/soc_top.sv
testbench/soc_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module soc_tb -Mdir obj_dir

output=$(./obj_dir/Vsoc_tb)
echo "$output"

echo "$output" | grep -q "No errors"
